//--- Bender.yml
package:
  name: sm83_alu_unit

sources:
  - files:
      - logic/sm83_alu_pkg.sv
      - logic/sm83_alu_ctrl_if.sv
      - logic/sm83_nibble_alu.sv
      - logic/sm83_alu_seq.sv
      - logic/sm83_alu_unit.sv
  - target: test
    files:
      - verification/sm83_alu_unit_tb.sv

//--- flist.f
logic/sm83_alu_pkg.sv
logic/sm83_alu_ctrl_if.sv
logic/sm83_nibble_alu.sv
logic/sm83_alu_seq.sv
logic/sm83_alu_unit.sv
verification/sm83_alu_unit_tb.sv

//--- logic/sm83_alu_ctrl_if.sv
/*
 * sm83 nibble alu control interface
 * carries the sequencer strobes and bus data into the nibble alu
 * and returns the bus and status outputs
 */

`timescale 1ns/1ps

interface sm83_alu_ctrl_if #(
	parameter int ALU_WIDTH = 4,
	localparam int WORD_W = 2 * ALU_WIDTH,
	localparam int BIT_W = $clog2(WORD_W)
);

	// bus data in both directions
	logic [WORD_W-1:0] din;
	logic [WORD_W-1:0] dout;

	// operand latch and shifter controls
	logic load_a;
	logic load_b;
	logic load_a_zero;
	logic load_b_zero;
	logic shift_l;
	logic shift_r;
	logic shift_in;
	logic carry_in;
	logic [BIT_W-1:0] bsel;

	// output bus source select, at most one is high in any cycle
	logic result_oe;
	logic shift_oe;
	logic op_a_oe;
	logic bs_oe;

	// slice controls, R S and V in the classic 4-bit alu description
	logic no_carry_out;
	logic force_carry;
	logic ignore_carry;
	logic negate;
	logic op_low;
	logic op_b_high;

	// status back to the sequencer
	logic carry;
	logic zero;
	logic sign;
	logic shift_dbh;
	logic shift_dbl;

	modport seq (
		output din, load_a, load_b, load_a_zero, load_b_zero,
		output shift_l, shift_r, shift_in, carry_in, bsel,
		output result_oe, shift_oe, op_a_oe, bs_oe,
		output no_carry_out, force_carry, ignore_carry, negate, op_low, op_b_high,
		input dout, carry, zero, sign, shift_dbh, shift_dbl
	);

	modport alu (
		input din, load_a, load_b, load_a_zero, load_b_zero,
		input shift_l, shift_r, shift_in, carry_in, bsel,
		input result_oe, shift_oe, op_a_oe, bs_oe,
		input no_carry_out, force_carry, ignore_carry, negate, op_low, op_b_high,
		output dout, carry, zero, sign, shift_dbh, shift_dbl
	);

endinterface

//--- logic/sm83_alu_pkg.sv
/*
 * sm83 arithmetic unit shared types
 * operation codes, micro-sequencer steps and the z n h c flag group
 */

package sm83_alu_pkg;

	// operation codes accepted by the arithmetic unit
	typedef enum logic [3:0] {
		ADD,
		ADC,
		SUB,
		SBC,
		AND,
		XOR,
		OR,
		CP,
		RL,
		RR,
		SLA,
		SRL,
		BIT,
		SET,
		RES
	} alu_op_e;

	// steps of the micro-sequencer
	// shifts go IDLE, SHIFT, DONE and everything else walks the two operand
	// loads and both nibble passes
	typedef enum logic [2:0] {
		IDLE,
		LOAD_A,
		LOAD_B,
		LOW,
		HIGH,
		SHIFT,
		DONE
	} seq_state_e;

	// flag group in the same bit order as the upper nibble of the F register
	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} sm83_flags_t;

endpackage

//--- logic/sm83_alu_seq.sv
/*
 * sm83 alu micro-sequencer
 * captures an operation, steps the nibble alu through its passes and
 * forms the byte result and the z n h c flags
 */

`timescale 1ns/1ps

module sm83_alu_seq import sm83_alu_pkg::*; #(
	parameter int ALU_WIDTH = 4,
	localparam int WORD_W = 2 * ALU_WIDTH,
	localparam int BIT_W = $clog2(WORD_W)
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input alu_op_e op,
	input logic [WORD_W-1:0] a,
	input logic [WORD_W-1:0] b,
	input logic [BIT_W-1:0] bit_sel,
	input sm83_flags_t flags_in,
	output logic [WORD_W-1:0] result,
	output sm83_flags_t flags,
	output logic done,
	output logic busy,
	sm83_alu_ctrl_if.seq ctrl
);

	seq_state_e state;
	alu_op_e op_q;

	// operands captured with start
	logic [WORD_W-1:0] a_q;
	logic [WORD_W-1:0] b_q;
	logic [BIT_W-1:0] bit_q;
	sm83_flags_t flags_q;

	// raw pass results, turned into the final flags in DONE
	logic [WORD_W-1:0] res_raw;
	logic h_raw;
	logic c_raw;
	logic z_raw;

	logic low_cin;
	logic use_mask;
	logic shift_left;
	logic shift_rot;
	logic [WORD_W-1:0] fin_result;
	sm83_flags_t fin_flags;

	function automatic logic op_is_shift(input alu_op_e o);
		return o inside {RL, RR, SLA, SRL};
	endfunction

	assign use_mask = op_q inside {BIT, SET, RES};
	assign shift_left = op_q inside {RL, SLA};
	// rotates feed the old carry back in, plain shifts feed zero
	assign shift_rot = op_q inside {RL, RR};

	// slice pattern and low pass carry for each operation class
	always_comb begin
		ctrl.no_carry_out = 1'b0;
		ctrl.force_carry = 1'b0;
		ctrl.ignore_carry = 1'b0;
		ctrl.negate = 1'b0;
		low_cin = 1'b0;
		case (op_q)
			ADC: low_cin = flags_q.c;
			// two's complement subtraction, so B is inverted and one is added
			SUB, CP: begin
				ctrl.negate = 1'b1;
				low_cin = 1'b1;
			end
			SBC: begin
				ctrl.negate = 1'b1;
				low_cin = !flags_q.c;
			end
			// AND needs a carry of one moving through every slice
			AND, BIT: begin
				ctrl.force_carry = 1'b1;
				low_cin = 1'b1;
			end
			// RES ands A with the inverted mask
			RES: begin
				ctrl.negate = 1'b1;
				ctrl.force_carry = 1'b1;
				low_cin = 1'b1;
			end
			OR, SET: begin
				ctrl.no_carry_out = 1'b1;
				ctrl.force_carry = 1'b1;
				ctrl.ignore_carry = 1'b1;
			end
			XOR: ctrl.no_carry_out = 1'b1;
			default: low_cin = 1'b0;
		endcase
	end

	// per-step strobes, one output enable and one load at a time
	always_comb begin
		ctrl.din = '0;
		ctrl.bsel = bit_q;
		ctrl.load_a = 1'b0;
		ctrl.load_b = 1'b0;
		ctrl.load_a_zero = 1'b0;
		ctrl.load_b_zero = 1'b0;
		ctrl.shift_l = 1'b0;
		ctrl.shift_r = 1'b0;
		ctrl.shift_in = 1'b0;
		ctrl.carry_in = 1'b0;
		ctrl.result_oe = 1'b0;
		ctrl.shift_oe = 1'b0;
		ctrl.op_a_oe = 1'b0;
		ctrl.bs_oe = 1'b0;
		ctrl.op_low = 1'b0;
		ctrl.op_b_high = 1'b0;
		case (state)
			LOAD_A: begin
				ctrl.din = a_q;
				ctrl.shift_oe = 1'b1;
				ctrl.load_a = 1'b1;
			end
			LOAD_B: begin
				ctrl.load_b = 1'b1;
				if (use_mask) begin
					ctrl.bs_oe = 1'b1;
				end else begin
					ctrl.din = b_q;
					ctrl.shift_oe = 1'b1;
				end
			end
			LOW: begin
				ctrl.op_low = 1'b1;
				ctrl.carry_in = low_cin;
			end
			// the low pass carry ripples into the high nibble
			HIGH: begin
				ctrl.op_b_high = 1'b1;
				ctrl.carry_in = h_raw;
				ctrl.result_oe = 1'b1;
			end
			// shifts skip the core so the operand latches are cleared instead
			SHIFT: begin
				ctrl.din = a_q;
				ctrl.shift_oe = 1'b1;
				ctrl.shift_l = shift_left;
				ctrl.shift_r = !shift_left;
				ctrl.shift_in = shift_rot & flags_q.c;
				ctrl.load_a_zero = 1'b1;
				ctrl.load_b_zero = 1'b1;
			end
			// CP and BIT hand back A unchanged, read straight from its latch
			DONE: ctrl.op_a_oe = op_q inside {CP, BIT};
			default: ctrl.din = '0;
		endcase
	end

	// final result and flag rules, applied in DONE
	always_comb begin
		fin_result = res_raw;
		fin_flags = '{z: z_raw, n: 1'b0, h: 1'b0, c: 1'b0};
		case (op_q)
			ADD, ADC: begin
				fin_flags.h = h_raw;
				fin_flags.c = c_raw;
			end
			// carries out of a subtraction are inverted borrows
			SUB, SBC, CP: begin
				fin_flags.n = 1'b1;
				fin_flags.h = !h_raw;
				fin_flags.c = !c_raw;
				if (op_q == CP) begin
					fin_result = ctrl.dout;
				end
			end
			AND: fin_flags.h = 1'b1;
			RL, RR, SLA, SRL: fin_flags.c = c_raw;
			BIT: begin
				fin_result = ctrl.dout;
				fin_flags.h = 1'b1;
				fin_flags.c = flags_q.c;
			end
			SET, RES: fin_flags = flags_q;
			default: fin_flags.c = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			op_q <= ADD;
			done <= 1'b0;
			result <= '0;
			flags <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						op_q <= op;
						state <= op_is_shift(op) ? SHIFT : LOAD_A;
					end
				end
				LOAD_A: state <= LOAD_B;
				LOAD_B: state <= LOW;
				LOW: state <= HIGH;
				HIGH: state <= DONE;
				SHIFT: state <= DONE;
				DONE: begin
					state <= IDLE;
					done <= 1'b1;
					result <= fin_result;
					flags <= fin_flags;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// operand capture and raw pass results
	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			a_q <= a;
			b_q <= b;
			bit_q <= bit_sel;
			flags_q <= flags_in;
		end
		if (state == LOW) begin
			h_raw <= ctrl.carry;
		end
		if (state == HIGH || state == SHIFT) begin
			// the msb of the bus comes back on the sign output
			res_raw <= {ctrl.sign, ctrl.dout[WORD_W-2:0]};
			z_raw <= ctrl.zero;
		end
		if (state == HIGH) begin
			c_raw <= ctrl.carry;
		end else if (state == SHIFT) begin
			c_raw <= shift_left ? ctrl.shift_dbh : ctrl.shift_dbl;
		end
	end

	assign busy = (state != IDLE);

endmodule

//--- logic/sm83_alu_unit.sv
/*
 * sm83 arithmetic unit top level
 * joins the micro-sequencer and the nibble alu behind plain ports
 */

`timescale 1ns/1ps

module sm83_alu_unit import sm83_alu_pkg::*; #(
	parameter int ALU_WIDTH = 4,
	localparam int WORD_W = 2 * ALU_WIDTH,
	localparam int BIT_W = $clog2(WORD_W)
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input alu_op_e op,
	input logic [WORD_W-1:0] a,
	input logic [WORD_W-1:0] b,
	input logic [BIT_W-1:0] bit_sel,
	input sm83_flags_t flags_in,
	output logic [WORD_W-1:0] result,
	output sm83_flags_t flags,
	output logic done,
	output logic busy
);

	// strobes and status between the sequencer and the datapath
	sm83_alu_ctrl_if #(.ALU_WIDTH(ALU_WIDTH)) alu_ctrl ();

	sm83_alu_seq #(.ALU_WIDTH(ALU_WIDTH)) u_seq (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.bit_sel(bit_sel),
		.flags_in(flags_in),
		.result(result),
		.flags(flags),
		.done(done),
		.busy(busy),
		.ctrl(alu_ctrl.seq)
	);

	sm83_nibble_alu #(.ALU_WIDTH(ALU_WIDTH)) u_alu (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(alu_ctrl.alu)
	);

endmodule

//--- logic/sm83_nibble_alu.sv
/*
 * sm83 nibble alu datapath
 * byte operands are processed one nibble per pass through a ripple of
 * slices, with a one-bit shifter, a bit mask generator and a bus select
 */

`timescale 1ns/1ps

module sm83_nibble_alu #(
	parameter int ALU_WIDTH = 4,
	localparam int WORD_W = 2 * ALU_WIDTH
) (
	input logic clk,
	input logic rst_n,
	sm83_alu_ctrl_if.alu ctrl
);

	// operand latches, each held as a high and a low half
	logic [ALU_WIDTH-1:0] a_hi;
	logic [ALU_WIDTH-1:0] a_lo;
	logic [ALU_WIDTH-1:0] b_hi;
	logic [ALU_WIDTH-1:0] b_lo;

	logic [ALU_WIDTH-1:0] core_a;
	logic [ALU_WIDTH-1:0] b_half;
	logic [ALU_WIDTH-1:0] core_b;
	logic [ALU_WIDTH-1:0] core_res;
	logic [ALU_WIDTH-1:0] res_lo;
	logic core_carry;

	logic [WORD_W-1:0] shifted;
	logic [WORD_W-1:0] bit_mask;
	logic [WORD_W-1:0] full_result;
	logic [WORD_W-1:0] bus;

	// one slice of the core, returns {carry out, result bit}
	// with r s v all low this is a full adder
	// s forces the internal carry-generate term, v lets any set input reach the
	// result, r blocks the carry to the next slice
	function automatic logic [1:0] slice(
		input logic x,
		input logic y,
		input logic cin,
		input logic r,
		input logic s,
		input logic v
	);
		logic no_gen;
		logic sum;
		logic cout;
		no_gen = !(((x | y) & cin) | (x & y) | s);
		sum = (x & y & cin) | ((x | y | cin) & (v | no_gen));
		cout = !(r | no_gen);
		return {cout, sum};
	endfunction

	// op_low picks the low half of A, op_b_high picks the high half of B
	assign core_a = ctrl.op_low ? a_lo : a_hi;
	assign b_half = ctrl.op_b_high ? b_hi : b_lo;
	assign core_b = ctrl.negate ? ~b_half : b_half;

	// ripple through the slices starting from the injected carry
	always_comb begin
		logic c;
		c = ctrl.carry_in;
		for (int i = 0; i < ALU_WIDTH; i++) begin
			{c, core_res[i]} = slice(core_a[i], core_b[i], c,
				ctrl.no_carry_out, ctrl.force_carry, ctrl.ignore_carry);
		end
		core_carry = c;
	end

	// the sequencer never raises both shift directions together
	always_comb begin
		if (ctrl.shift_l) begin
			shifted = {ctrl.din[WORD_W-2:0], ctrl.shift_in};
		end else if (ctrl.shift_r) begin
			shifted = {ctrl.shift_in, ctrl.din[WORD_W-1:1]};
		end else begin
			shifted = ctrl.din;
		end
	end

	// single set bit at the position named by bsel
	assign bit_mask = {{(WORD_W-1){1'b0}}, 1'b1} << ctrl.bsel;

	// high half straight from the core, low half from the earlier pass
	assign full_result = {core_res, res_lo};

	// bus source select; an idle bus reads as zero
	always_comb begin
		if (ctrl.result_oe) begin
			bus = full_result;
		end else if (ctrl.shift_oe) begin
			bus = shifted;
		end else if (ctrl.op_a_oe) begin
			bus = {a_hi, a_lo};
		end else if (ctrl.bs_oe) begin
			bus = bit_mask;
		end else begin
			bus = '0;
		end
	end

	// operands load from the bus on the falling edge, halfway through the
	// cycle that carries the load strobe
	always_ff @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			a_hi <= '0;
			a_lo <= '0;
		end else if (ctrl.load_a) begin
			{a_hi, a_lo} <= bus;
		end else if (ctrl.load_a_zero) begin
			a_hi <= '0;
			a_lo <= '0;
		end
	end

	always_ff @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			b_hi <= '0;
			b_lo <= '0;
		end else if (ctrl.load_b) begin
			{b_hi, b_lo} <= bus;
		end else if (ctrl.load_b_zero) begin
			b_hi <= '0;
			b_lo <= '0;
		end
	end

	// low pass result, held for the high pass that follows
	always_ff @(posedge clk) begin
		if (ctrl.op_low) begin
			res_lo <= core_res;
		end
	end

	assign ctrl.dout = bus;
	assign ctrl.carry = core_carry;
	assign ctrl.zero = (bus == '0);
	assign ctrl.sign = bus[WORD_W-1];
	// shifter edge bits come from the unshifted input
	assign ctrl.shift_dbh = ctrl.din[WORD_W-1];
	assign ctrl.shift_dbl = ctrl.din[0];

endmodule

//--- verification/sm83_alu_unit_tb.sv
/*
 * sm83 arithmetic unit testbench
 * applies a table of directed and random operations, checks result, flags
 * and done timing against a model of the instruction rules
 */

`timescale 1ns/1ps

module sm83_alu_unit_tb import sm83_alu_pkg::*; ();

	localparam int N_DIRECTED = 25;
	localparam int N_RANDOM = 48;
	localparam int N_VEC = N_DIRECTED + N_RANDOM;
	localparam int DONE_TIMEOUT = 40;

	// one table entry, stimulus followed by the expected response
	typedef struct packed {
		alu_op_e op;
		logic [7:0] a;
		logic [7:0] b;
		logic [2:0] bit_sel;
		sm83_flags_t flags_in;
		logic [7:0] exp_result;
		sm83_flags_t exp_flags;
	} vec_t;

	logic clk;
	logic rst_n;
	logic start;
	alu_op_e op;
	logic [7:0] a;
	logic [7:0] b;
	logic [2:0] bit_sel;
	sm83_flags_t flags_in;
	logic [7:0] result;
	sm83_flags_t flags;
	logic done;
	logic busy;

	vec_t vectors [N_VEC];
	int n_vec;
	int tests;
	int checks;
	int errors;
	bit timed_out;
	integer seed;

	sm83_alu_unit #(.ALU_WIDTH(4)) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.bit_sel(bit_sel),
		.flags_in(flags_in),
		.result(result),
		.flags(flags),
		.done(done),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// expected result and flags taken from the instruction rules
	// returns {result, z n h c}
	function automatic logic [11:0] model_op(
		input alu_op_e o,
		input logic [7:0] x,
		input logic [7:0] y,
		input logic [2:0] bs,
		input sm83_flags_t fi
	);
		logic [8:0] wide;
		logic [4:0] low;
		logic cy;
		logic [7:0] mask;
		logic [7:0] r;
		sm83_flags_t f;
		mask = 8'h01 << bs;
		// carry for ADC and borrow for SBC both come from the incoming C
		cy = (o == ADC || o == SBC) ? fi.c : 1'b0;
		r = 8'h00;
		f = '0;
		case (o)
			ADD, ADC: begin
				wide = {1'b0, x} + {1'b0, y} + {8'h00, cy};
				low = {1'b0, x[3:0]} + {1'b0, y[3:0]} + {4'h0, cy};
				r = wide[7:0];
				f.h = low[4];
				f.c = wide[8];
			end
			// a negative difference leaves the top bit of the wider word set
			SUB, SBC, CP: begin
				wide = {1'b0, x} - {1'b0, y} - {8'h00, cy};
				low = {1'b0, x[3:0]} - {1'b0, y[3:0]} - {4'h0, cy};
				r = (o == CP) ? x : wide[7:0];
				f.z = (wide[7:0] == 8'h00);
				f.n = 1'b1;
				f.h = low[4];
				f.c = wide[8];
			end
			AND: begin
				r = x & y;
				f.h = 1'b1;
			end
			OR: r = x | y;
			XOR: r = x ^ y;
			RL: begin
				r = {x[6:0], fi.c};
				f.c = x[7];
			end
			RR: begin
				r = {fi.c, x[7:1]};
				f.c = x[0];
			end
			SLA: begin
				r = {x[6:0], 1'b0};
				f.c = x[7];
			end
			SRL: begin
				r = {1'b0, x[7:1]};
				f.c = x[0];
			end
			BIT: begin
				r = x;
				f.z = !x[bs];
				f.h = 1'b1;
				f.c = fi.c;
			end
			SET: r = x | mask;
			RES: r = x & ~mask;
			default: r = 8'h00;
		endcase
		if (o != CP && o != BIT) begin
			f.z = (r == 8'h00);
		end
		// bit set and reset leave every flag as it came in
		if (o == SET || o == RES) begin
			f = fi;
		end
		return {r, f};
	endfunction

	task automatic add_vec(
		input alu_op_e o,
		input logic [7:0] x,
		input logic [7:0] y,
		input logic [2:0] bs,
		input sm83_flags_t fi,
		input logic [7:0] exp_r,
		input sm83_flags_t exp_f
	);
		vectors[n_vec] = {o, x, y, bs, fi, exp_r, exp_f};
		n_vec++;
	endtask

	// hand-worked corner cases, flags written as z n h c
	task automatic load_directed();
		add_vec(ADD, 8'h3a, 8'hc6, 3'd0, 4'b0000, 8'h00, 4'b1011);
		add_vec(ADD, 8'h0f, 8'h01, 3'd0, 4'b0000, 8'h10, 4'b0010);
		add_vec(ADC, 8'he1, 8'h0f, 3'd0, 4'b0001, 8'hf1, 4'b0010);
		add_vec(ADC, 8'hff, 8'h00, 3'd0, 4'b0001, 8'h00, 4'b1011);
		add_vec(SUB, 8'h3e, 8'h3e, 3'd0, 4'b0000, 8'h00, 4'b1100);
		add_vec(SUB, 8'h3e, 8'h0f, 3'd0, 4'b0000, 8'h2f, 4'b0110);
		add_vec(SUB, 8'h3e, 8'h40, 3'd0, 4'b0000, 8'hfe, 4'b0101);
		add_vec(SBC, 8'h3b, 8'h2a, 3'd0, 4'b0001, 8'h10, 4'b0100);
		add_vec(SBC, 8'h3b, 8'h4f, 3'd0, 4'b0001, 8'heb, 4'b0111);
		add_vec(CP, 8'h3c, 8'h2f, 3'd0, 4'b0000, 8'h3c, 4'b0110);
		add_vec(CP, 8'h3c, 8'h3c, 3'd0, 4'b0000, 8'h3c, 4'b1100);
		add_vec(AND, 8'h5a, 8'h3f, 3'd0, 4'b0000, 8'h1a, 4'b0010);
		add_vec(AND, 8'hf0, 8'h0f, 3'd0, 4'b0001, 8'h00, 4'b1010);
		add_vec(OR, 8'h5a, 8'h0f, 3'd0, 4'b0001, 8'h5f, 4'b0000);
		add_vec(XOR, 8'hff, 8'hff, 3'd0, 4'b0000, 8'h00, 4'b1000);
		add_vec(XOR, 8'h5a, 8'h0f, 3'd0, 4'b0000, 8'h55, 4'b0000);
		// b carries junk on shifts and bit operations, it must be ignored
		add_vec(RL, 8'h80, 8'ha5, 3'd0, 4'b0000, 8'h00, 4'b1001);
		add_vec(RL, 8'h11, 8'ha5, 3'd0, 4'b0001, 8'h23, 4'b0000);
		add_vec(RR, 8'h8a, 8'ha5, 3'd0, 4'b0001, 8'hc5, 4'b0000);
		add_vec(SLA, 8'hff, 8'ha5, 3'd0, 4'b0001, 8'hfe, 4'b0001);
		add_vec(SRL, 8'h01, 8'ha5, 3'd0, 4'b0001, 8'h00, 4'b1001);
		add_vec(BIT, 8'h80, 8'ha5, 3'd7, 4'b0000, 8'h80, 4'b0010);
		add_vec(BIT, 8'hfe, 8'ha5, 3'd0, 4'b0001, 8'hfe, 4'b1011);
		add_vec(SET, 8'h00, 8'ha5, 3'd3, 4'b1010, 8'h08, 4'b1010);
		add_vec(RES, 8'hff, 8'ha5, 3'd7, 4'b0101, 8'h7f, 4'b0101);
	endtask

	task automatic fill_random();
		int unsigned pick;
		alu_op_e o;
		logic [7:0] x;
		logic [7:0] y;
		logic [2:0] bs;
		sm83_flags_t fi;
		logic [11:0] exp;
		for (int i = 0; i < N_RANDOM; i++) begin
			pick = $random(seed);
			o = alu_op_e'(pick % 15);
			x = $random(seed);
			y = $random(seed);
			bs = $random(seed);
			fi = $random(seed);
			exp = model_op(o, x, y, bs, fi);
			add_vec(o, x, y, bs, fi, exp[11:4], exp[3:0]);
		end
	endtask

	task automatic expect_true(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("[ERROR] %0t ns: %s", $time, msg);
		end
		if (!ok) begin
			errors++;
		end
	endtask

	// called 1 ns after a rising edge, start is seen on the next edge
	task automatic launch(
		input alu_op_e o,
		input logic [7:0] x,
		input logic [7:0] y,
		input logic [2:0] bs,
		input sm83_flags_t fi
	);
		op = o;
		a = x;
		b = y;
		bit_sel = bs;
		flags_in = fi;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	// counts rising edges until done shows up
	task automatic wait_done(output int edges);
		edges = 0;
		while (done !== 1'b1 && edges < DONE_TIMEOUT) begin
			@(posedge clk);
			#1;
			edges++;
		end
		if (done !== 1'b1) begin
			timed_out = 1'b1;
			$display("timeout: done did not arrive within %0d cycles, sequencer state %s",
				DONE_TIMEOUT, DUT.u_seq.state.name());
		end
	endtask

	task automatic run_vec(input int idx);
		vec_t v;
		alu_op_e o;
		int edges;
		int exp_edges;
		int err_before;
		v = vectors[idx];
		o = v.op;
		err_before = errors;
		// shifts bypass the nibble passes
		exp_edges = (o == RL || o == RR || o == SLA || o == SRL) ? 2 : 5;
		launch(o, v.a, v.b, v.bit_sel, v.flags_in);
		expect_true(busy === 1'b1, $sformatf("test %0d busy low after start", idx));
		wait_done(edges);
		if (!timed_out) begin
			expect_true(edges == exp_edges,
				$sformatf("test %0d done after %0d edges, expected %0d", idx, edges, exp_edges));
			expect_true(result === v.exp_result,
				$sformatf("test %0d %s result %02h, expected %02h", idx, o.name(), result,
				v.exp_result));
			expect_true(flags === v.exp_flags,
				$sformatf("test %0d %s flags %04b, expected %04b", idx, o.name(), flags,
				v.exp_flags));
			expect_true(busy === 1'b0, $sformatf("test %0d busy still high with done", idx));
			$display("test %0d %s a=%02h b=%02h bit=%0d -> %02h znhc=%04b %s", idx, o.name(),
				v.a, v.b, v.bit_sel, result, flags, (errors == err_before) ? "ok" : "mismatch");
		end
	endtask

	// a second start while busy must be ignored and must not give a second done
	task automatic check_dropped_start();
		int edges;
		int extra;
		int err_before;
		err_before = errors;
		extra = 0;
		launch(ADD, 8'h12, 8'h34, 3'd0, 4'b0000);
		launch(SUB, 8'hff, 8'h01, 3'd0, 4'b0001);
		wait_done(edges);
		if (!timed_out) begin
			// one edge already went by while the second start was driven
			expect_true(edges + 1 == 5,
				$sformatf("overlap test done after %0d edges, expected 5", edges + 1));
			expect_true(result === 8'h46, $sformatf("overlap test result %02h, expected 46", result));
			expect_true(flags === 4'b0000, $sformatf("overlap test flags %04b, expected 0000", flags));
			for (int i = 0; i < 12; i++) begin
				@(posedge clk);
				#1;
				if (done === 1'b1) begin
					extra++;
				end
			end
			expect_true(extra == 0, $sformatf("dropped start produced %0d extra done", extra));
			$display("test overlap start while busy -> %02h znhc=%04b %s", result, flags,
				(errors == err_before) ? "ok" : "mismatch");
		end
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		op = ADD;
		a = 8'h00;
		b = 8'h00;
		bit_sel = 3'd0;
		flags_in = '0;
		seed = 32'h7db8_2bbb;
		n_vec = 0;
		tests = 0;
		checks = 0;
		errors = 0;
		timed_out = 1'b0;
		load_directed();
		fill_random();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		expect_true(done === 1'b0 && busy === 1'b0, "done or busy high after reset");
		expect_true(result === 8'h00 && flags === 4'b0000, "result or flags not zero after reset");
		for (int i = 0; i < n_vec && !timed_out; i++) begin
			run_vec(i);
			tests++;
		end
		if (!timed_out) begin
			check_dropped_start();
			tests++;
		end
		$display("tests %0d, checks %0d, errors %0d, timeout %0d", tests, checks, errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
